// File: plicPkg.sv
`default_nettype none

package plicPkg;

  // largest source count that fits one 32-bit pending or enable word
  localparam int maxSrc = 31;

  // priority of a source or a context threshold, 0 never interrupts
  typedef logic [2:0] priority_t;

  // source id, 0 means no source
  typedef logic [5:0] srcId_t;

  // arbiter result for one context
  typedef struct packed {
    logic   valid;
    srcId_t id;
  } claim_t;

  ////////////////////////////////////////
  // register map, word aligned
  ////////////////////////////////////////
  localparam logic [23:0] priorityBase   = 24'h000000;
  localparam logic [23:0] pendingAddr    = 24'h001000;
  localparam logic [23:0] enableAddr0    = 24'h002000;
  localparam logic [23:0] enableAddr1    = 24'h002080;
  localparam logic [23:0] thresholdAddr0 = 24'h200000;
  localparam logic [23:0] claimAddr0     = 24'h200004;
  localparam logic [23:0] thresholdAddr1 = 24'h201000;
  localparam logic [23:0] claimAddr1     = 24'h201004;

endpackage

`default_nettype wire

// File: ahbPkg.sv
`default_nettype none

package ahbPkg;

  // HTRANS encoding
  typedef enum logic [1:0] {
    idle   = 2'b00,
    busy   = 2'b01,
    nonseq = 2'b10,
    seq    = 2'b11
  } htrans_t;

  // address phase signals as seen by the slave
  typedef struct packed {
    logic        sel;
    logic [27:0] addr;
    logic        write;
    htrans_t     trans;
    logic        ready;
  } ahbReq_t;

  // one register access per cycle
  // read uses the live address phase, write uses the delayed one
  typedef struct packed {
    logic        rdEn;
    logic        wrEn;
    logic [23:0] rdAddr;
    logic [23:0] wrAddr;
  } regAccess_t;

endpackage

`default_nettype wire

// File: ahbSlavePort.sv
`timescale 1ns/1ps
`default_nettype none

module ahbSlavePort #(
  parameter int dataWidth = 32
) (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  ahbPkg::ahbReq_t        hreq,
  input  logic [dataWidth-1:0]   hwdata,
  input  logic [31:0]            rdWord,
  output ahbPkg::regAccess_t     access,
  output logic [31:0]            wrData,
  output logic [dataWidth-1:0]   hrdata,
  output logic                   hreadyOut,
  output logic                   hresp
);
  import ahbPkg::*;

  logic        xferStart;
  logic [23:0] wordAddr;
  logic        wrPend;
  logic [23:0] addrQ;

  // valid transfer in the address phase
  assign xferStart = hreq.sel & hreq.ready & (hreq.trans != idle);
  // registers are 32 bits, drop the byte offset
  assign wordAddr  = {hreq.addr[23:2], 2'b00};

  // write data arrives one cycle after its address
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wrPend <= 1'b0;
      addrQ  <= '0;
    end else begin
      wrPend <= xferStart & hreq.write;
      addrQ  <= wordAddr;
    end
  end

  always_comb begin
    access.rdEn   = xferStart & ~hreq.write;
    access.rdAddr = wordAddr;
    access.wrEn   = wrPend;
    access.wrAddr = addrQ;
  end

  ////////////////////////////////////////
  // lane select
  ////////////////////////////////////////
  if (dataWidth == 64) begin : gLane64
    // address bit 2 picks the upper word
    assign wrData = addrQ[2] ? hwdata[63:32] : hwdata[31:0];
    assign hrdata = addrQ[2] ? {rdWord, 32'b0} : {32'b0, rdWord};
  end else begin : gLane32
    assign wrData = hwdata[31:0];
    assign hrdata = rdWord;
  end

  // zero wait states, always OKAY
  assign hreadyOut = 1'b1;
  assign hresp     = 1'b0;

  busWidth: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (dataWidth == 32) || (dataWidth == 64));

endmodule

`default_nettype wire

// File: plicRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module plicRegFile #(
  parameter int numSrc = 7
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  ahbPkg::regAccess_t              access,
  input  logic [31:0]                     wrData,
  input  logic [numSrc:1]                 pending,
  input  plicPkg::claim_t                 claim0,
  input  plicPkg::claim_t                 claim1,
  output logic [31:0]                     rdWord,
  output plicPkg::priority_t [numSrc:1]   srcPriority,
  output logic [numSrc:1]                 enable0,
  output logic [numSrc:1]                 enable1,
  output plicPkg::priority_t              threshold0,
  output plicPkg::priority_t              threshold1,
  output logic [numSrc:1]                 claimEn,
  output logic [numSrc:1]                 completeEn
);
  import plicPkg::*;

  logic        claimRd0;
  logic        claimRd1;
  logic        isComplete;
  claim_t      claimSel;
  logic [31:0] rdNext;

  ////////////////////////////////////////
  // register writes
  ////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      srcPriority <= '0;
      enable0     <= '0;
      enable1     <= '0;
      threshold0  <= '0;
      threshold1  <= '0;
    end else if (access.wrEn) begin
      case (access.wrAddr)
        // bit 0 of an enable word is source 0, never stored
        enableAddr0:    enable0    <= wrData[numSrc:1];
        enableAddr1:    enable1    <= wrData[numSrc:1];
        thresholdAddr0: threshold0 <= wrData[2:0];
        thresholdAddr1: threshold1 <= wrData[2:0];
        default: begin
          // priority n sits at 4*n, n = 0 has no register
          for (int s = 1; s <= numSrc; s++) begin
            if (access.wrAddr == priorityBase + 24'(4 * s)) begin
              srcPriority[s] <= wrData[2:0];
            end
          end
        end
      endcase
    end
  end

  // writing an id to either claim address completes it
  assign isComplete = access.wrEn &
                      ((access.wrAddr == claimAddr0) | (access.wrAddr == claimAddr1));

  always_comb begin
    completeEn = '0;
    for (int s = 1; s <= numSrc; s++) begin
      completeEn[s] = isComplete & (wrData[5:0] == srcId_t'(s));
    end
  end

  ////////////////////////////////////////
  // claim on read
  ////////////////////////////////////////
  assign claimRd0 = access.rdEn & (access.rdAddr == claimAddr0);
  assign claimRd1 = access.rdEn & (access.rdAddr == claimAddr1);
  assign claimSel = claimRd1 ? claim1 : claim0;

  // one-hot of the id being claimed this cycle
  always_comb begin
    claimEn = '0;
    for (int s = 1; s <= numSrc; s++) begin
      claimEn[s] = (claimRd0 | claimRd1) & (claimSel.id == srcId_t'(s));
    end
  end

  ////////////////////////////////////////
  // read data
  ////////////////////////////////////////
  always_comb begin
    rdNext = '0;
    case (access.rdAddr)
      pendingAddr:    rdNext = {maxSrc'(pending), 1'b0};
      enableAddr0:    rdNext = {maxSrc'(enable0), 1'b0};
      enableAddr1:    rdNext = {maxSrc'(enable1), 1'b0};
      thresholdAddr0: rdNext = 32'(threshold0);
      thresholdAddr1: rdNext = 32'(threshold1);
      claimAddr0:     rdNext = 32'(claim0.id);
      claimAddr1:     rdNext = 32'(claim1.id);
      default: begin
        // unmapped addresses fall through as 0
        for (int s = 1; s <= numSrc; s++) begin
          if (access.rdAddr == priorityBase + 24'(4 * s)) begin
            rdNext = 32'(srcPriority[s]);
          end
        end
      end
    endcase
    // bus reads 0 when no read is in flight
    if (!access.rdEn) begin
      rdNext = '0;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      rdWord <= '0;
    end else begin
      rdWord <= rdNext;
    end
  end

  // a claim read must never mark a source when its arbiter has no winner
  claimNeedsValid: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (claimEn != '0) |-> claimSel.valid);

endmodule

`default_nettype wire

// File: plicGateway.sv
`timescale 1ns/1ps
`default_nettype none

module plicGateway #(
  parameter int numSrc = 7
) (
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic [numSrc:1]   irqSrc,
  input  logic [numSrc:1]   claimEn,
  input  logic [numSrc:1]   completeEn,
  output logic [numSrc:1]   pending
);

  // set by a claim, cleared by the matching complete
  logic [numSrc:1] inProgress;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      pending    <= '0;
      inProgress <= '0;
    end else begin
      // level request latches only while the source is idle
      // claim wins over a new request on the same edge
      pending    <= (pending | (irqSrc & ~inProgress)) & ~claimEn;
      inProgress <= (inProgress | claimEn) & ~completeEn;
    end
  end

  // a claim only ever lands on a source that is waiting
  claimOnPending: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (claimEn & ~pending) == '0);

endmodule

`default_nettype wire

// File: plicArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module plicArbiter #(
  parameter int numSrc = 7
) (
  input  logic [numSrc:1]                 pending,
  input  logic [numSrc:1]                 enable,
  input  plicPkg::priority_t [numSrc:1]   srcPriority,
  input  plicPkg::priority_t              threshold,
  output plicPkg::claim_t                 claim,
  output logic                            irq
);
  import plicPkg::*;

  // priority level rows by source columns
  logic [7:1][numSrc:1] irqMatrix;
  logic [7:1]           levelHasReq;
  priority_t            topLevel;
  logic [numSrc:1]      topReqs;

  ////////////////////////////////////////
  // request matrix
  ////////////////////////////////////////
  always_comb begin
    for (int p = 1; p <= 7; p++) begin
      for (int s = 1; s <= numSrc; s++) begin
        // active means pending and enabled in this context
        irqMatrix[p][s] = pending[s] & enable[s] & (srcPriority[s] == priority_t'(p));
      end
      levelHasReq[p] = |irqMatrix[p];
    end
  end

  // highest level with any request, and the sources at that level
  always_comb begin
    topLevel = '0;
    topReqs  = '0;
    for (int p = 1; p <= 7; p++) begin
      if (levelHasReq[p]) begin
        topLevel = priority_t'(p);
        topReqs  = irqMatrix[p];
      end
    end
  end

  ////////////////////////////////////////
  // pick the winner
  ////////////////////////////////////////
  // scan downwards so the lowest id is the last one kept
  always_comb begin
    claim = '0;
    for (int s = numSrc; s >= 1; s--) begin
      if (topReqs[s]) begin
        claim.id = srcId_t'(s);
      end
    end
    // claim ignores the threshold
    claim.valid = |topReqs;
  end

  // interrupt only above the context threshold, level 0 never fires
  assign irq = (topLevel > threshold);

endmodule

`default_nettype wire

// File: plic.sv
`timescale 1ns/1ps
`default_nettype none

module plic #(
  parameter int numSrc    = 7,
  parameter int dataWidth = 32
) (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  ahbPkg::ahbReq_t        hreq,
  input  logic [dataWidth-1:0]   hwdata,
  input  logic [numSrc:1]        irqSrc,
  output logic [dataWidth-1:0]   hrdata,
  output logic                   hreadyOut,
  output logic                   hresp,
  output logic                   meip,
  output logic                   seip
);
  import plicPkg::*;
  import ahbPkg::*;

  regAccess_t               access;
  logic [31:0]              wrData;
  logic [31:0]              rdWord;
  priority_t [numSrc:1]     srcPriority;
  logic [numSrc:1]          enable0;
  logic [numSrc:1]          enable1;
  priority_t                threshold0;
  priority_t                threshold1;
  logic [numSrc:1]          claimEn;
  logic [numSrc:1]          completeEn;
  logic [numSrc:1]          pending;
  claim_t                   claim0;
  claim_t                   claim1;

  ////////////////////////////////////////
  // bus side
  ////////////////////////////////////////
  ahbSlavePort #(.dataWidth(dataWidth)) busPort (
    .HCLK(HCLK), .HRESETn(HRESETn), .hreq(hreq), .hwdata(hwdata), .rdWord(rdWord),
    .access(access), .wrData(wrData), .hrdata(hrdata), .hreadyOut(hreadyOut), .hresp(hresp)
  );

  plicRegFile #(.numSrc(numSrc)) regFile (
    .HCLK(HCLK), .HRESETn(HRESETn), .access(access), .wrData(wrData), .pending(pending),
    .claim0(claim0), .claim1(claim1), .rdWord(rdWord), .srcPriority(srcPriority),
    .enable0(enable0), .enable1(enable1), .threshold0(threshold0), .threshold1(threshold1),
    .claimEn(claimEn), .completeEn(completeEn)
  );

  ////////////////////////////////////////
  // interrupt side
  ////////////////////////////////////////
  plicGateway #(.numSrc(numSrc)) gateway (
    .HCLK(HCLK), .HRESETn(HRESETn), .irqSrc(irqSrc), .claimEn(claimEn),
    .completeEn(completeEn), .pending(pending)
  );

  // context 0, machine mode
  plicArbiter #(.numSrc(numSrc)) ctx0Arb (
    .pending(pending), .enable(enable0), .srcPriority(srcPriority),
    .threshold(threshold0), .claim(claim0), .irq(meip)
  );

  // context 1, supervisor mode
  plicArbiter #(.numSrc(numSrc)) ctx1Arb (
    .pending(pending), .enable(enable1), .srcPriority(srcPriority),
    .threshold(threshold1), .claim(claim1), .irq(seip)
  );

endmodule

`default_nettype wire

// File: tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
  parameter int periodNs    = 10,
  parameter int resetCycles = 5
) (
  output logic HCLK,
  output logic HRESETn
);

  // free running bus clock
  initial begin
    HCLK = 1'b0;
    forever #(periodNs / 2) HCLK = ~HCLK;
  end

  // reset held low for a few edges, released on a rising edge
  initial begin
    HRESETn = 1'b0;
    repeat (resetCycles) @(posedge HCLK);
    HRESETn <= 1'b1;
  end

endmodule

`default_nettype wire

// File: plicTb.sv
`timescale 1ns/1ps
`default_nettype none

module plicTb;
  import plicPkg::*;
  import ahbPkg::*;

  localparam int numSrc = 7;

  logic                 HCLK;
  logic                 HRESETn;
  ahbReq_t              hreq;
  logic [31:0]          hwdata;
  logic [numSrc:1]      irqSrc;
  logic [31:0]          hrdata;
  logic                 hreadyOut;
  logic                 hresp;
  logic                 meip;
  logic                 seip;
  logic                 xferOn;

  // reference model state
  logic [numSrc:1]      mPending;
  logic [numSrc:1]      mInProg;
  logic [numSrc:1]      mEn0;
  logic [numSrc:1]      mEn1;
  priority_t [numSrc:1] mPrio;
  priority_t            mThr0;
  priority_t            mThr1;
  logic                 mWrQ;
  logic [23:0]          mWrAddrQ;

  integer seed = 15922;
  int     errCount = 0;
  int     testNum = 0;
  int     passCount = 0;
  int     failCount = 0;

  tbClockGen #(.periodNs(10), .resetCycles(5)) clkGen (.HCLK(HCLK), .HRESETn(HRESETn));

  plic #(.numSrc(numSrc), .dataWidth(32)) DUT (
    .HCLK(HCLK), .HRESETn(HRESETn), .hreq(hreq), .hwdata(hwdata), .irqSrc(irqSrc),
    .hrdata(hrdata), .hreadyOut(hreadyOut), .hresp(hresp), .meip(meip), .seip(seip)
  );

  assign xferOn = hreq.sel & hreq.ready & (hreq.trans != idle);

  ////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////
  // highest priority wins, strict compare keeps the lowest id on a tie
  function automatic claim_t refArb(input logic [numSrc:1] pend, input logic [numSrc:1] en,
                                    input priority_t [numSrc:1] prio, input priority_t thr,
                                    output logic irq);
    claim_t    c;
    priority_t best;
    c = '0;
    best = '0;
    for (int s = 1; s <= numSrc; s++) begin
      if (pend[s] && en[s] && (prio[s] > best)) begin
        best = prio[s];
        c.id = srcId_t'(s);
      end
    end
    c.valid = (best != 0);
    irq = (best > thr);
    return c;
  endfunction

  // expected bus read value from the model
  function automatic logic [31:0] refRead(input logic [23:0] a);
    logic [31:0] d;
    claim_t      c;
    logic        irqNone;
    d = '0;
    case (a)
      pendingAddr:    d = 32'({mPending, 1'b0});
      enableAddr0:    d = 32'({mEn0, 1'b0});
      enableAddr1:    d = 32'({mEn1, 1'b0});
      thresholdAddr0: d = 32'(mThr0);
      thresholdAddr1: d = 32'(mThr1);
      claimAddr0: begin
        c = refArb(mPending, mEn0, mPrio, mThr0, irqNone);
        d = 32'(c.id);
      end
      claimAddr1: begin
        c = refArb(mPending, mEn1, mPrio, mThr1, irqNone);
        d = 32'(c.id);
      end
      default: begin
        for (int s = 1; s <= numSrc; s++) begin
          if (a == 24'(4 * s)) d = 32'(mPrio[s]);
        end
      end
    endcase
    return d;
  endfunction

  // model follows the bus as the DUT sees it, one update per edge
  always @(posedge HCLK or negedge HRESETn) begin
    logic [numSrc:1] mask;
    claim_t          c;
    logic            irqNone;
    if (!HRESETn) begin
      mPending = '0;
      mInProg  = '0;
      mEn0     = '0;
      mEn1     = '0;
      mPrio    = '0;
      mThr0    = '0;
      mThr1    = '0;
      mWrQ     = 1'b0;
      mWrAddrQ = '0;
    end else begin
      mask = '0;
      c = '0;
      if (xferOn && !hreq.write) begin
        if (hreq.addr[23:0] == claimAddr0) c = refArb(mPending, mEn0, mPrio, mThr0, irqNone);
        if (hreq.addr[23:0] == claimAddr1) c = refArb(mPending, mEn1, mPrio, mThr1, irqNone);
        for (int s = 1; s <= numSrc; s++) begin
          if (c.valid && (c.id == srcId_t'(s))) mask[s] = 1'b1;
        end
      end
      // a claim clears pending, a held source waits while in progress
      mPending = (mPending | (irqSrc & ~mInProg)) & ~mask;
      mInProg  = mInProg | mask;
      if (mWrQ) begin
        case (mWrAddrQ)
          enableAddr0:    mEn0  = hwdata[numSrc:1];
          enableAddr1:    mEn1  = hwdata[numSrc:1];
          thresholdAddr0: mThr0 = hwdata[2:0];
          thresholdAddr1: mThr1 = hwdata[2:0];
          claimAddr0, claimAddr1: begin
            for (int s = 1; s <= numSrc; s++) begin
              if (hwdata[5:0] == srcId_t'(s)) mInProg[s] = 1'b0;
            end
          end
          default: begin
            for (int s = 1; s <= numSrc; s++) begin
              if (mWrAddrQ == 24'(4 * s)) mPrio[s] = hwdata[2:0];
            end
          end
        endcase
      end
      mWrQ     = xferOn && hreq.write;
      mWrAddrQ = hreq.addr[23:0];
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic compareWord(input logic [31:0] got, input logic [31:0] exp, input string name);
    if (got !== exp) begin
      $display("error at %0t ns: %s read %h, expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic compareId(input srcId_t got, input srcId_t exp, input string name);
    if (got !== exp) begin
      $display("error at %0t ns: %s claimed id %0d, expected %0d", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic compareIrq(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      errCount++;
    end
  endtask

  // interrupt lines and bus response checked against the model on every falling edge
  always @(negedge HCLK) begin
    claim_t c;
    logic   exp0;
    logic   exp1;
    if (HRESETn) begin
      c = refArb(mPending, mEn0, mPrio, mThr0, exp0);
      c = refArb(mPending, mEn1, mPrio, mThr1, exp1);
      compareIrq(meip, exp0, "meip");
      compareIrq(seip, exp1, "seip");
      // zero wait states and OKAY on every cycle
      compareIrq(hreadyOut, 1'b1, "hreadyOut");
      compareIrq(hresp, 1'b0, "hresp");
    end
  end

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////
  function automatic ahbReq_t makeReq(input logic [23:0] a, input logic wr);
    ahbReq_t r;
    r.sel   = 1'b1;
    r.addr  = {4'h0, a};
    r.write = wr;
    r.trans = nonseq;
    r.ready = 1'b1;
    return r;
  endfunction

  // samples the edge that ends the address phase
  task automatic waitReady();
    int n;
    n = 0;
    @(posedge HCLK);
    while (!hreadyOut && n < 16) begin
      @(posedge HCLK);
      n++;
    end
    if (!hreadyOut) begin
      $display("timeout: hreadyOut stayed low at %0t ns", $time);
      errCount++;
    end
  endtask

  // returns after the write edge, on a falling edge
  task automatic writeReg(input logic [23:0] a, input logic [31:0] d);
    @(posedge HCLK);
    hreq <= makeReq(a, 1'b1);
    waitReady();
    hreq   <= '0;
    hwdata <= d;
    @(posedge HCLK);
    @(negedge HCLK);
  endtask

  // expected value taken from the model during the address phase
  task automatic readReg(input logic [23:0] a, output logic [31:0] got, output logic [31:0] exp);
    @(posedge HCLK);
    hreq <= makeReq(a, 1'b0);
    @(negedge HCLK);
    exp = refRead(a);
    waitReady();
    hreq <= '0;
    @(negedge HCLK);
    got = hrdata;
  endtask

  task automatic readCheck(input logic [23:0] a, input string name, output logic [31:0] got);
    logic [31:0] exp;
    readReg(a, got, exp);
    compareWord(got, exp, name);
  endtask

  task automatic claimCheck(input int ctx, input string name, output srcId_t id);
    logic [31:0] got;
    logic [31:0] exp;
    readReg((ctx == 0) ? claimAddr0 : claimAddr1, got, exp);
    compareId(got[5:0], exp[5:0], name);
    id = got[5:0];
  endtask

  task automatic waitIrq(input int ctx);
    int n;
    n = 0;
    while (((ctx == 0) ? meip : seip) !== 1'b1 && n < 32) begin
      @(negedge HCLK);
      n++;
    end
    if (((ctx == 0) ? meip : seip) !== 1'b1) begin
      $display("timeout: interrupt of context %0d never rose", ctx);
      errCount++;
    end
  endtask

  // release sources, claim and complete what is left, clear all registers
  task automatic drainSources();
    srcId_t id;
    int     n;
    @(posedge HCLK);
    irqSrc <= '0;
    for (int s = 1; s <= numSrc; s++) writeReg(24'(4 * s), 32'd1);
    writeReg(enableAddr0, 32'hFFFF_FFFE);
    writeReg(thresholdAddr0, 32'd0);
    n = 0;
    id = srcId_t'(1);
    while (id != 0 && n < 16) begin
      claimCheck(0, "drain claim", id);
      if (id != 0) writeReg(claimAddr0, 32'(id));
      n++;
    end
    if (id != 0) begin
      $display("timeout: sources still pending after drain");
      errCount++;
    end
    for (int s = 1; s <= numSrc; s++) writeReg(claimAddr0, 32'(s));
    for (int s = 1; s <= numSrc; s++) writeReg(24'(4 * s), 32'd0);
    writeReg(enableAddr0, 32'd0);
    writeReg(enableAddr1, 32'd0);
    writeReg(thresholdAddr0, 32'd0);
    writeReg(thresholdAddr1, 32'd0);
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testNum++;
    if (errCount == errBefore) passCount++;
    else failCount++;
    $display("test %0d %s: %s", testNum, name, (errCount == errBefore) ? "passed" : "failed");
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] got;
    logic [31:0] r;
    srcId_t      id;
    int          errBefore;
    int          n;
    hreq   = '0;
    hwdata = '0;
    irqSrc = '0;
    n = 0;
    while (!HRESETn && n < 100) begin
      @(posedge HCLK);
      n++;
    end
    if (!HRESETn) begin
      $display("timeout: reset never released");
      errCount++;
    end

    // 1. reset values
    errBefore = errCount;
    for (int s = 1; s <= numSrc; s++) readCheck(24'(4 * s), "reset priority", got);
    readCheck(pendingAddr, "reset pending", got);
    readCheck(enableAddr0, "reset enable0", got);
    readCheck(enableAddr1, "reset enable1", got);
    readCheck(thresholdAddr0, "reset threshold0", got);
    readCheck(thresholdAddr1, "reset threshold1", got);
    claimCheck(0, "reset claim0", id);
    claimCheck(1, "reset claim1", id);
    compareIrq(meip, 1'b0, "reset meip");
    compareIrq(seip, 1'b0, "reset seip");
    finishTest("reset values", errBefore);

    // 2. readback, upper data bits ignored
    errBefore = errCount;
    for (int s = 1; s <= numSrc; s++) writeReg(24'(4 * s), 32'hA5A5_A5A0 | 32'(8 - s));
    for (int s = 1; s <= numSrc; s++) readCheck(24'(4 * s), "priority readback", got);
    writeReg(enableAddr0, 32'hFFFF_FFFF);
    readCheck(enableAddr0, "enable0 readback", got);
    compareWord(got, 32'h0000_00FE, "enable0 bit 0");
    writeReg(enableAddr1, 32'h0000_0055);
    readCheck(enableAddr1, "enable1 readback", got);
    compareWord(got, 32'h0000_0054, "enable1 bit 0");
    writeReg(thresholdAddr0, 32'h0000_000D);
    writeReg(thresholdAddr1, 32'h0000_0006);
    readCheck(thresholdAddr0, "threshold0 readback", got);
    readCheck(thresholdAddr1, "threshold1 readback", got);
    readCheck(24'h000000, "priority 0", got);
    compareWord(got, 32'h0, "priority 0");
    readCheck(24'h000100, "unmapped priority", got);
    compareWord(got, 32'h0, "unmapped priority");
    readCheck(24'h003000, "unmapped enable", got);
    compareWord(got, 32'h0, "unmapped enable");
    drainSources();
    finishTest("register readback", errBefore);

    // 3. one source, two contexts with different thresholds
    errBefore = errCount;
    writeReg(24'(4 * 3), 32'd4);
    writeReg(enableAddr0, 32'h0000_0008);
    writeReg(enableAddr1, 32'h0000_0008);
    writeReg(thresholdAddr0, 32'd2);
    writeReg(thresholdAddr1, 32'd5);
    @(posedge HCLK);
    irqSrc[3] <= 1'b1;
    waitIrq(0);
    readCheck(pendingAddr, "pending source 3", got);
    compareWord(got, 32'h0000_0008, "pending source 3");
    compareIrq(seip, 1'b0, "seip at threshold 5");
    writeReg(thresholdAddr1, 32'd3);
    waitIrq(1);
    writeReg(enableAddr0, 32'd0);
    compareIrq(meip, 1'b0, "meip disabled");
    compareIrq(seip, 1'b1, "seip enabled");
    drainSources();
    finishTest("pending and enable", errBefore);

    // 4. arbitration, fixed tie first, then random
    errBefore = errCount;
    writeReg(24'(4 * 1), 32'd3);
    writeReg(24'(4 * 2), 32'd5);
    writeReg(24'(4 * 4), 32'd5);
    writeReg(24'(4 * 6), 32'd5);
    writeReg(enableAddr0, 32'h0000_00FE);
    @(posedge HCLK);
    irqSrc <= 7'b0101011;
    claimCheck(0, "tie claim", id);
    compareId(id, srcId_t'(2), "tie lowest id");
    drainSources();
    for (int it = 0; it < 12; it++) begin
      for (int s = 1; s <= numSrc; s++) begin
        r = $random(seed);
        writeReg(24'(4 * s), 32'(r[2:0]));
      end
      r = $random(seed);
      writeReg(enableAddr0, {24'h0, r[7:1], 1'b0});
      r = $random(seed);
      writeReg(enableAddr1, {24'h0, r[7:1], 1'b0});
      r = $random(seed);
      @(posedge HCLK);
      irqSrc <= r[numSrc:1];
      // alternate contexts so both claim addresses see traffic
      for (int k = 0; k < 4; k++) begin
        claimCheck(k % 2, "random claim", id);
        if (id != 0) writeReg((k % 2 == 0) ? claimAddr0 : claimAddr1, 32'(id));
      end
      drainSources();
    end
    finishTest("claim arbitration", errBefore);

    // 5. held source stays quiet until complete
    errBefore = errCount;
    writeReg(24'(4 * 5), 32'd2);
    writeReg(enableAddr0, 32'h0000_0020);
    @(posedge HCLK);
    irqSrc[5] <= 1'b1;
    waitIrq(0);
    claimCheck(0, "claim source 5", id);
    compareId(id, srcId_t'(5), "claim source 5");
    readCheck(pendingAddr, "pending after claim", got);
    compareWord(got, 32'h0, "pending after claim");
    readCheck(pendingAddr, "pending while in progress", got);
    compareWord(got, 32'h0, "pending while in progress");
    compareIrq(meip, 1'b0, "meip while in progress");
    writeReg(claimAddr0, 32'd5);
    waitIrq(0);
    readCheck(pendingAddr, "pending after complete", got);
    compareWord(got, 32'h0000_0020, "pending after complete");
    drainSources();
    finishTest("claim and complete", errBefore);

    // 6. threshold sweep on a priority 4 source
    errBefore = errCount;
    writeReg(24'(4 * 6), 32'd4);
    writeReg(enableAddr0, 32'h0000_0040);
    writeReg(enableAddr1, 32'h0000_0040);
    @(posedge HCLK);
    irqSrc[6] <= 1'b1;
    waitIrq(0);
    for (int t = 0; t < 8; t++) begin
      writeReg(thresholdAddr0, 32'(t));
      writeReg(thresholdAddr1, 32'(7 - t));
      compareIrq(meip, logic'(4 > t), "meip sweep");
      compareIrq(seip, logic'(4 > (7 - t)), "seip sweep");
    end
    drainSources();
    finishTest("threshold sweep", errBefore);

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             testNum, passCount, failCount, errCount);
    if (errCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // whole run bound
  initial begin
    #500000;
    $display("timeout: simulation did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
plicPkg.sv
ahbPkg.sv
ahbSlavePort.sv
plicRegFile.sv
plicGateway.sv
plicArbiter.sv
plic.sv
tbClockGen.sv
plicTb.sv

// File: Makefile
TOP = plicTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f tb.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
